// File: build.f
+incdir+include
source/axis_cdc_pkg.sv
source/axis_async_fifo.sv
source/axis_frame_filter.sv
source/axis_filter_regs.sv
source/axis_cdc_top.sv
bench/clk_gen.sv
bench/tb_axis_cdc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_axis_cdc
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
EXTRA     ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS EXTRA"

test:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/axis_cdc_golden.hex
// kind in [31:28]: 1 cfg write, 2 input beat, 3 expected beat, 4 read check, 5 drain, f end
// cfg: addr [17:16] data [15:0]; beats: last [9] user [8] data [7:0]
40000000 40010000 40020000
// drop off, flagged frames pass
20000011 20000212
30000011 30000212
20000121 20000022 20000223
30000121 30000022 30000223
50000000
40010002 40020000
// drop on
10000001
40000001
20000131 20000232
20000041 20000242
30000041 30000242
20000351
20000261
30000261
50000000
40010004 40020002
// long burst past the fifo depth
20000070 20000071 20000072 20000073 20000074 20000175
20000076 20000077 20000078 20000079 2000007a 2000007b
2000007c 2000007d 2000007e 2000007f 20000080 20000281
30000070 30000071 30000072 30000073 30000074 30000175
30000076 30000077 30000078 30000079 3000007a 3000007b
3000007c 3000007d 3000007e 3000007f 30000080 30000281
50000000
40010005 40020002
// clear counters
10030000
40010000 40020000
f0000000

// File: bench/tb_axis_cdc.sv
`include "axis_cdc_config.svh"

module tb_axis_cdc
  import axis_cdc_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_RECORDS = 256;

  logic                       input_clk;
  logic                       output_clk;
  logic                       output_rst_sync3;
  axis_beat_t                 s_beat;
  logic                       s_tvalid;
  logic                       s_tready;
  axis_beat_t                 m_beat;
  logic                       m_tvalid;
  logic                       m_tready;
  logic                       cfg_wr;
  logic                       cfg_rd;
  logic [`CFG_ADDR_WIDTH-1:0] cfg_addr;
  logic [`STAT_WIDTH-1:0]     cfg_wdata;
  logic [`STAT_WIDTH-1:0]     cfg_rdata;
  logic                       cfg_rvalid;

  logic [31:0] golden [MAX_RECORDS];
  int          nrec;
  int          cycles;
  logic [31:0] lfsr;
  logic [31:0] rec;
  logic        beat_taken;
  axis_beat_t  wq [$];
  axis_beat_t  eq [$];

  clk_gen #(.PERIOD_NS(8.0))  u_out_clk (.clk(output_clk));
  clk_gen #(.PERIOD_NS(12.0)) u_in_clk  (.clk(input_clk));

  axis_cdc_top u_axis_cdc_top (
    .input_clk        (input_clk),
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .s_beat           (s_beat),
    .s_tvalid         (s_tvalid),
    .s_tready         (s_tready),
    .m_beat           (m_beat),
    .m_tvalid         (m_tvalid),
    .m_tready         (m_tready),
    .cfg_wr           (cfg_wr),
    .cfg_rd           (cfg_rd),
    .cfg_addr         (cfg_addr),
    .cfg_wdata        (cfg_wdata),
    .cfg_rdata        (cfg_rdata),
    .cfg_rvalid       (cfg_rvalid)
  );

  // galois lfsr with taps for x^32+x^22+x^2+x+1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_beat(input axis_beat_t got, input axis_beat_t exp);
    if (got !== exp) begin
      $display("Error at %0t: beat mismatch, got last=%b user=%b data=%h, want %b %b %h",
               $time, got.last, got.user, got.data, exp.last, exp.user, exp.data);
      stop_with_failure("output stream differs from the golden file");
    end
  endtask

  task automatic check_word(input logic [`STAT_WIDTH-1:0] got,
                            input logic [`STAT_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s read %h, want %h", $time, what, got, exp);
      stop_with_failure("register readback differs from the golden file");
    end
  endtask

  task automatic cfg_write(input logic [`CFG_ADDR_WIDTH-1:0] addr,
                           input logic [`STAT_WIDTH-1:0] data);
    @(posedge output_clk);
    #1;
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge output_clk);
    #1;
    cfg_wr = 1'b0;
  endtask

  // read data and rvalid come exactly one cycle after the strobe.
  task automatic cfg_read_check(input logic [`CFG_ADDR_WIDTH-1:0] addr,
                                input logic [`STAT_WIDTH-1:0] exp);
    @(posedge output_clk);
    #1;
    cfg_rd   = 1'b1;
    cfg_addr = addr;
    @(posedge output_clk);
    #1;
    cfg_rd = 1'b0;
    if (cfg_rvalid !== 1'b1) begin
      stop_with_failure("cfg_rvalid did not rise one cycle after the read strobe");
    end else begin
      check_word(cfg_rdata, exp, $sformatf("address %0d", addr));
    end
    @(posedge output_clk);
    #1;
    if (cfg_rvalid !== 1'b0) begin
      stop_with_failure("cfg_rvalid stayed high for more than one cycle");
    end
  endtask

  // wait until all written beats are taken and all expected beats seen.
  task automatic drain();
    while (wq.size() != 0 || eq.size() != 0 || s_tvalid) begin
      @(posedge output_clk);
    end
    repeat (3) @(posedge output_clk);
  endtask

  // write side.
  // s_tready only moves on input_clk, so its value after the edge holds until the next one.
  initial begin
    forever begin
      @(posedge input_clk);
      #1;
      if (beat_taken) begin
        void'(wq.pop_front());
      end
      if (wq.size() != 0) begin
        s_beat   = wq[0];
        s_tvalid = 1'b1;
      end else begin
        s_tvalid = 1'b0;
      end
      beat_taken = s_tvalid && s_tready;
    end
  end

  // read side with random back-pressure.
  initial begin
    forever begin
      @(posedge output_clk);
      #1;
      lfsr     = lfsr_next(lfsr);
      m_tready = lfsr[0];
      if (!output_rst_sync3 && m_tvalid && m_tready) begin
        if (eq.size() == 0) begin
          stop_with_failure("an output beat appeared that the golden file does not expect");
        end else begin
          check_beat(m_beat, eq.pop_front());
        end
      end
    end
  end

  always @(posedge output_clk) begin
    cycles <= cycles + 1;
    if (nrec != 0 && cycles > 40 * nrec) begin
      stop_with_failure("timeout: the run took longer than the cycle limit");
    end
  end

  initial begin
    init_inputs();
  end

  task automatic init_inputs();
    output_rst_sync3 = 1'b1;
    s_beat           = '0;
    s_tvalid         = 1'b0;
    m_tready         = 1'b0;
    cfg_wr           = 1'b0;
    cfg_rd           = 1'b0;
    cfg_addr         = '0;
    cfg_wdata        = '0;
    cycles           = 0;
    nrec             = 0;
    beat_taken       = 1'b0;
    lfsr             = 32'h3e62d002;
  endtask

  initial begin
    #0;
    $readmemh("bench/axis_cdc_golden.hex", golden);
    while (nrec < MAX_RECORDS && golden[nrec][31:28] != 4'hf) begin
      nrec++;
    end
    if (nrec == 0) begin
      stop_with_failure("the golden file holds no records");
    end
    repeat (10) @(posedge output_clk);
    #1;
    output_rst_sync3 = 1'b0;
    if (m_tvalid !== 1'b0) begin
      stop_with_failure("m_tvalid is not low after reset");
    end
    if (s_tready !== 1'b0) begin
      stop_with_failure("s_tready is not low while the write-side reset is active");
    end
    for (int i = 0; i < nrec; i++) begin
      rec = golden[i];
      case (rec[31:28])
        4'h1: begin
          drain();
          cfg_write(rec[17:16], rec[15:0]);
        end
        4'h2: wq.push_back(axis_beat_t'(rec[9:0]));
        4'h3: eq.push_back(axis_beat_t'(rec[9:0]));
        4'h4: begin
          drain();
          cfg_read_check(rec[17:16], rec[15:0]);
        end
        4'h5: drain();
        default: stop_with_failure("the golden file holds an unknown record kind");
      endcase
    end
    drain();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: bench/clk_gen.sv
module clk_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

// File: source/axis_cdc_top.sv
`include "axis_cdc_config.svh"

module axis_cdc_top
  import axis_cdc_pkg::*;
(
  input  logic                       input_clk,
  input  logic                       output_clk,
  input  logic                       output_rst_sync3,
  input  axis_beat_t                 s_beat,
  input  logic                       s_tvalid,
  output logic                       s_tready,
  output axis_beat_t                 m_beat,
  output logic                       m_tvalid,
  input  logic                       m_tready,
  input  logic                       cfg_wr,
  input  logic                       cfg_rd,
  input  logic [`CFG_ADDR_WIDTH-1:0] cfg_addr,
  input  logic [`STAT_WIDTH-1:0]     cfg_wdata,
  output logic [`STAT_WIDTH-1:0]     cfg_rdata,
  output logic                       cfg_rvalid
);

  axis_beat_t   fifo_beat;
  logic         fifo_tvalid;
  logic         fifo_tready;
  logic         drop_enable;
  logic         stats_clear;
  frame_stats_t stats;

  axis_async_fifo u_axis_async_fifo (
    .input_clk        (input_clk),
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .s_beat           (s_beat),
    .s_tvalid         (s_tvalid),
    .s_tready         (s_tready),
    .m_beat           (fifo_beat),
    .m_tvalid         (fifo_tvalid),
    .m_tready         (fifo_tready)
  );

  axis_frame_filter u_axis_frame_filter (
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .s_beat           (fifo_beat),
    .s_tvalid         (fifo_tvalid),
    .s_tready         (fifo_tready),
    .m_beat           (m_beat),
    .m_tvalid         (m_tvalid),
    .m_tready         (m_tready),
    .drop_enable      (drop_enable),
    .stats_clear      (stats_clear),
    .stats            (stats)
  );

  axis_filter_regs u_axis_filter_regs (
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .cfg_wr           (cfg_wr),
    .cfg_rd           (cfg_rd),
    .cfg_addr         (cfg_addr),
    .cfg_wdata        (cfg_wdata),
    .cfg_rdata        (cfg_rdata),
    .cfg_rvalid       (cfg_rvalid),
    .drop_enable      (drop_enable),
    .stats_clear      (stats_clear),
    .stats            (stats)
  );

endmodule

// File: source/axis_filter_regs.sv
`include "axis_cdc_config.svh"

module axis_filter_regs
  import axis_cdc_pkg::*;
(
  input  logic                       output_clk,
  input  logic                       output_rst_sync3,
  input  logic                       cfg_wr,
  input  logic                       cfg_rd,
  input  logic [`CFG_ADDR_WIDTH-1:0] cfg_addr,
  input  logic [`STAT_WIDTH-1:0]     cfg_wdata,
  output logic [`STAT_WIDTH-1:0]     cfg_rdata,
  output logic                       cfg_rvalid,
  output logic                       drop_enable,
  output logic                       stats_clear,
  input  frame_stats_t               stats
);

  localparam logic [`CFG_ADDR_WIDTH-1:0] ADDR_CTRL    = 2'd0;
  localparam logic [`CFG_ADDR_WIDTH-1:0] ADDR_PASSED  = 2'd1;
  localparam logic [`CFG_ADDR_WIDTH-1:0] ADDR_DROPPED = 2'd2;
  localparam logic [`CFG_ADDR_WIDTH-1:0] ADDR_CLEAR   = 2'd3;

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      drop_enable <= 1'b0;
      stats_clear <= 1'b0;
    end else begin
      stats_clear <= cfg_wr && (cfg_addr == ADDR_CLEAR);
      if (cfg_wr && (cfg_addr == ADDR_CTRL)) begin
        drop_enable <= cfg_wdata[0];
      end
    end
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      cfg_rvalid <= 1'b0;
    end else begin
      cfg_rvalid <= cfg_rd;
    end
  end

  // clear address reads back as zero.
  always_ff @(posedge output_clk) begin
    if (cfg_rd) begin
      case (cfg_addr)
        ADDR_CTRL:    cfg_rdata <= {{(`STAT_WIDTH-1){1'b0}}, drop_enable};
        ADDR_PASSED:  cfg_rdata <= stats.frames_passed;
        ADDR_DROPPED: cfg_rdata <= stats.frames_dropped;
        default:      cfg_rdata <= '0;
      endcase
    end
  end

endmodule

// File: source/axis_frame_filter.sv
module axis_frame_filter
  import axis_cdc_pkg::*;
(
  input  logic         output_clk,
  input  logic         output_rst_sync3,
  input  axis_beat_t   s_beat,
  input  logic         s_tvalid,
  output logic         s_tready,
  output axis_beat_t   m_beat,
  output logic         m_tvalid,
  input  logic         m_tready,
  input  logic         drop_enable,
  input  logic         stats_clear,
  output frame_stats_t stats
);

  logic in_frame;
  logic dropping;
  logic drop_now;
  logic accepted;

  // decision is made on the first beat and held to the last.
  assign drop_now = in_frame ? dropping : (s_beat.user & drop_enable);

  assign m_beat   = s_beat;
  assign m_tvalid = s_tvalid & ~drop_now;
  assign s_tready = drop_now | m_tready;
  assign accepted = s_tvalid & s_tready;

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      in_frame <= 1'b0;
      dropping <= 1'b0;
    end else if (accepted) begin
      in_frame <= ~s_beat.last;
      dropping <= drop_now;
    end
  end

  // counters step on the last beat of each frame.
  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      stats <= '0;
    end else if (stats_clear) begin
      stats <= '0;
    end else if (accepted && s_beat.last) begin
      if (drop_now) begin
        stats.frames_dropped <= stats.frames_dropped + 1'b1;
      end else begin
        stats.frames_passed <= stats.frames_passed + 1'b1;
      end
    end
  end

endmodule

// File: source/axis_async_fifo.sv
`include "axis_cdc_config.svh"

module axis_async_fifo
  import axis_cdc_pkg::*;
(
  input  logic       input_clk,
  input  logic       output_clk,
  input  logic       output_rst_sync3,
  input  axis_beat_t s_beat,
  input  logic       s_tvalid,
  output logic       s_tready,
  output axis_beat_t m_beat,
  output logic       m_tvalid,
  input  logic       m_tready
);

  localparam int AW    = `AXIS_ADDR_WIDTH;
  localparam int DEPTH = 1 << AW;

  function automatic logic [AW:0] bin2gray(input logic [AW:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  axis_beat_t mem [DEPTH];

  logic [2:0]  input_rst_sync;
  logic        input_rst;

  logic [AW:0] wr_ptr;
  logic [AW:0] wr_ptr_next;
  logic [AW:0] wr_ptr_gray;
  logic [AW:0] rd_ptr_gray_sync1;
  logic [AW:0] rd_ptr_gray_sync2;

  logic [AW:0] rd_ptr;
  logic [AW:0] rd_ptr_next;
  logic [AW:0] rd_ptr_gray;
  logic [AW:0] wr_ptr_gray_sync1;
  logic [AW:0] wr_ptr_gray_sync2;

  logic full;
  logic empty;
  logic write;
  logic read;

  // reset enters the write domain through three flops.
  always_ff @(posedge input_clk) begin
    input_rst_sync <= {input_rst_sync[1:0], output_rst_sync3};
  end

  assign input_rst = input_rst_sync[2];

  // full when the top two gray bits differ and the rest match.
  assign full = (wr_ptr_gray == {~rd_ptr_gray_sync2[AW:AW-1], rd_ptr_gray_sync2[AW-2:0]});
  assign empty = (rd_ptr_gray == wr_ptr_gray_sync2);

  assign s_tready    = ~full & ~input_rst;
  assign write       = s_tvalid & s_tready;
  assign wr_ptr_next = wr_ptr + 1'b1;

  always_ff @(posedge input_clk) begin
    if (input_rst) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else if (write) begin
      wr_ptr      <= wr_ptr_next;
      wr_ptr_gray <= bin2gray(wr_ptr_next);
    end
  end

  always_ff @(posedge input_clk) begin
    if (write) begin
      mem[wr_ptr[AW-1:0]] <= s_beat;
    end
  end

  always_ff @(posedge input_clk) begin
    if (input_rst) begin
      rd_ptr_gray_sync1 <= '0;
      rd_ptr_gray_sync2 <= '0;
    end else begin
      rd_ptr_gray_sync1 <= rd_ptr_gray;
      rd_ptr_gray_sync2 <= rd_ptr_gray_sync1;
    end
  end

  // refill the output register when it is empty or being taken.
  assign read        = (m_tready | ~m_tvalid) & ~empty;
  assign rd_ptr_next = rd_ptr + 1'b1;

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else if (read) begin
      rd_ptr      <= rd_ptr_next;
      rd_ptr_gray <= bin2gray(rd_ptr_next);
    end
  end

  always_ff @(posedge output_clk) begin
    if (read) begin
      m_beat <= mem[rd_ptr[AW-1:0]];
    end
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      m_tvalid <= 1'b0;
    end else if (m_tready | ~m_tvalid) begin
      m_tvalid <= ~empty;
    end
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      wr_ptr_gray_sync1 <= '0;
      wr_ptr_gray_sync2 <= '0;
    end else begin
      wr_ptr_gray_sync1 <= wr_ptr_gray;
      wr_ptr_gray_sync2 <= wr_ptr_gray_sync1;
    end
  end

endmodule

// File: source/axis_cdc_pkg.sv
`include "axis_cdc_config.svh"

package axis_cdc_pkg;

  // one stream beat, stored in the fifo as is.
  typedef struct packed {
    logic                        last;
    logic                        user;
    logic [`AXIS_DATA_WIDTH-1:0] data;
  } axis_beat_t;

  // frame counters kept by the filter.
  typedef struct packed {
    logic [`STAT_WIDTH-1:0] frames_passed;
    logic [`STAT_WIDTH-1:0] frames_dropped;
  } frame_stats_t;

endpackage

// File: include/axis_cdc_config.svh
`ifndef AXIS_CDC_CONFIG_SVH
`define AXIS_CDC_CONFIG_SVH

// fifo holds 2**AXIS_ADDR_WIDTH beats.
`define AXIS_ADDR_WIDTH 4
`define AXIS_DATA_WIDTH 8

`define CFG_ADDR_WIDTH 2
`define STAT_WIDTH 16

`endif
